//--- verilog/conbus_pkg.sv
// shared types and sizes for the six-master wishbone interconnect
// and the word memory hanging off its slave port
package conbus_pkg;

	// number of masters on the shared bus
	localparam int N_MASTERS = 6;

	// memory depth in 32-bit words
	localparam int SRAM_WORDS = 256;
	// word index width, taken from adr[9:2]
	localparam int SRAM_AW = $clog2(SRAM_WORDS);

	// classic wishbone field widths
	localparam int ADR_W = 32;
	localparam int DAT_W = 32;
	// one select bit per byte lane
	localparam int SEL_W = DAT_W / 8;
	localparam int CTI_W = 3;
	// enough bits to name any of the six masters
	localparam int GNT_W = 3;

	// byte address
	typedef logic [ADR_W-1:0] wb_adr_t;
	// data word, both directions
	typedef logic [DAT_W-1:0] wb_dat_t;
	// byte lane select
	typedef logic [SEL_W-1:0] wb_sel_t;
	// cycle type tag, carried but never acted on
	typedef logic [CTI_W-1:0] wb_cti_t;
	// index of the master that owns the bus
	typedef logic [GNT_W-1:0] gnt_idx_t;
	// word index into the memory array
	typedef logic [SRAM_AW-1:0] sram_idx_t;

	// master to slave, same field order as the old flat bus
	// 32 + 3 + 4 + 32 + 1 + 1 + 1 = 74 bits of payload and control
	typedef struct packed {
		wb_adr_t adr;
		wb_cti_t cti;
		wb_sel_t sel;
		wb_dat_t dat;
		logic    we;
		logic    cyc;
		logic    stb;
	} wb_m2s_t;

	// slave to master
	// read data is only meaningful while ack is high
	typedef struct packed {
		wb_dat_t dat;
		logic    ack;
	} wb_s2m_t;

endpackage

//--- verilog/conbus_arb6.sv
`timescale 1ns/1ps
// round-robin arbiter for the six-master shared bus
// the owner keeps the grant for as long as its cyc stays high
module conbus_arb6 (
	input  logic                             sys_clk,
	input  logic                             rst_n_i,
	input  logic [conbus_pkg::N_MASTERS-1:0] req_i,
	output conbus_pkg::gnt_idx_t             gnt_o
);

	// candidate index, one bit wider so the wrap test can see 6 and 7
	typedef logic [conbus_pkg::GNT_W:0] cand_t;

	// current owner
	conbus_pkg::gnt_idx_t gnt_q;
	// owner for the next cycle
	conbus_pkg::gnt_idx_t gnt_d;
	// owner has dropped cyc
	logic owner_idle;
	// first requester already taken in this search
	logic found;
	// index under test in the search loop
	cand_t cand;

	// the grant register never leaves 0..5, so this index stays in range
	assign owner_idle = !req_i[gnt_q];

	// next owner
	always_comb begin
		gnt_d = gnt_q;
		found = 1'b0;
		cand = '0;
		if (owner_idle) begin
			// search upward from owner + 1, wrapping past master 5
			// the owner itself comes last and is idle, so it is skipped
			for (int k = 1; k < conbus_pkg::N_MASTERS; k++) begin
				cand = cand_t'(gnt_q) + cand_t'(k);
				if (cand >= cand_t'(conbus_pkg::N_MASTERS)) begin
					cand = cand - cand_t'(conbus_pkg::N_MASTERS);
				end
				// lowest distance from the owner wins
				if (!found && req_i[cand[conbus_pkg::GNT_W-1:0]]) begin
					gnt_d = cand[conbus_pkg::GNT_W-1:0];
					found = 1'b1;
				end
			end
		end
		// no requester at all: grant stays parked on the old owner
	end

	// grant register, master 0 out of reset
	always_ff @(posedge sys_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			gnt_q <= '0;
		end else begin
			gnt_q <= gnt_d;
		end
	end

	// registered grant straight out
	// mux and ack steering decode it combinationally downstream
	assign gnt_o = gnt_q;

endmodule

//--- verilog/conbus6x1.sv
`timescale 1ns/1ps
// shared-bus multiplexer from six wishbone masters onto one slave
// the granted master drives the slave, ack is steered back to it only
module conbus6x1 (
	input  logic                sys_clk,
	input  logic                rst_n_i,
	input  conbus_pkg::wb_m2s_t m_bus_i [conbus_pkg::N_MASTERS],
	output conbus_pkg::wb_s2m_t m_bus_o [conbus_pkg::N_MASTERS],
	output conbus_pkg::wb_m2s_t s_bus_o,
	input  conbus_pkg::wb_s2m_t s_bus_i
);

	// cyc of every master, one bit each
	logic [conbus_pkg::N_MASTERS-1:0] req;
	// current owner from the arbiter
	conbus_pkg::gnt_idx_t gnt;
	// one-hot grant, combinational
	logic [conbus_pkg::N_MASTERS-1:0] gnt_dec;

	// requests are the cyc lines, stb plays no part in arbitration
	always_comb begin
		for (int i = 0; i < conbus_pkg::N_MASTERS; i++) begin
			req[i] = m_bus_i[i].cyc;
		end
	end

	conbus_arb6 u_arb (
		.sys_clk (sys_clk),
		.rst_n_i (rst_n_i),
		.req_i   (req),
		.gnt_o   (gnt)
	);

	// decode the grant in the same cycle it is used
	// a registered decode would route ack one cycle late after a handover
	always_comb begin
		for (int i = 0; i < conbus_pkg::N_MASTERS; i++) begin
			gnt_dec[i] = (gnt == conbus_pkg::gnt_idx_t'(i));
		end
	end

	// slave side gets the owner's whole struct
	// an out-of-range grant leaves the bus idle with cyc and stb low
	always_comb begin
		s_bus_o = '0;
		for (int i = 0; i < conbus_pkg::N_MASTERS; i++) begin
			if (gnt_dec[i]) begin
				s_bus_o = m_bus_i[i];
			end
		end
	end

	// return path
	for (genvar g = 0; g < conbus_pkg::N_MASTERS; g++) begin : g_ret
		// read data fans out to everyone, only ack qualifies it
		assign m_bus_o[g].dat = s_bus_i.dat;
		// ack only reaches the owner
		assign m_bus_o[g].ack = s_bus_i.ack & gnt_dec[g];
	end

endmodule

//--- verilog/wb_sram.sv
`timescale 1ns/1ps
// wishbone slave word memory, byte-lane writes under sel
// one registered ack per strobe, read data registered alongside it
module wb_sram (
	input  logic                sys_clk,
	input  logic                rst_n_i,
	input  conbus_pkg::wb_m2s_t bus_i,
	output conbus_pkg::wb_s2m_t bus_o
);

	// storage, contents undefined until written
	conbus_pkg::wb_dat_t mem [conbus_pkg::SRAM_WORDS];
	// word index, upper address bits wrap
	conbus_pkg::sram_idx_t idx;
	// ack register
	logic ack_q;
	// new request accepted at this edge
	logic take;
	// read data register
	conbus_pkg::wb_dat_t rd_q;

	// adr[9:2], byte offset bits dropped
	assign idx = bus_i.adr[conbus_pkg::SRAM_AW+1:2];

	// accept only while ack is low
	// the master still shows stb in the ack cycle, which must not count twice
	assign take = bus_i.cyc & bus_i.stb & !ack_q;

	// ack pulses for exactly one cycle per accepted strobe
	always_ff @(posedge sys_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= take;
		end
	end

	// array access on the edge that raises ack
	always_ff @(posedge sys_clk) begin
		if (take) begin
			// old word comes back on a write too, masters ignore it
			rd_q <= mem[idx];
			if (bus_i.we) begin
				// lanes with sel low keep their old byte
				for (int b = 0; b < conbus_pkg::SEL_W; b++) begin
					if (bus_i.sel[b]) begin
						mem[idx][8*b +: 8] <= bus_i.dat[8*b +: 8];
					end
				end
			end
		end
	end

	// data valid while ack is high
	assign bus_o.dat = rd_q;
	assign bus_o.ack = ack_q;

endmodule

//--- verilog/conbus_top.sv
`timescale 1ns/1ps
// six-master wishbone subsystem
// shared-bus interconnect in front of a single word memory
module conbus_top (
	input  logic                sys_clk,
	input  logic                rst_n_i,
	input  conbus_pkg::wb_m2s_t m_bus_i [conbus_pkg::N_MASTERS],
	output conbus_pkg::wb_s2m_t m_bus_o [conbus_pkg::N_MASTERS]
);

	// slave bus, owner's request towards the memory
	conbus_pkg::wb_m2s_t s_m2s;
	// slave bus, memory response back to the interconnect
	conbus_pkg::wb_s2m_t s_s2m;

	// arbiter and mux
	// grant moves only when the owner drops cyc
	conbus6x1 u_conbus (
		.sys_clk (sys_clk),
		.rst_n_i (rst_n_i),
		.m_bus_i (m_bus_i),
		.m_bus_o (m_bus_o),
		.s_bus_o (s_m2s),
		.s_bus_i (s_s2m)
	);

	// sole slave
	// no address decode, every address lands here and wraps
	wb_sram u_sram (
		.sys_clk (sys_clk),
		.rst_n_i (rst_n_i),
		.bus_i   (s_m2s),
		.bus_o   (s_s2m)
	);

endmodule

//--- bench/conbus_asserts.sv
`timescale 1ns/1ps
// grant and ack rules of the shared-bus mux
module conbus_asserts (
	input logic                 sys_clk,
	input logic                 rst_n_i,
	input conbus_pkg::wb_m2s_t  m_bus_i [conbus_pkg::N_MASTERS],
	input conbus_pkg::wb_s2m_t  m_bus_o [conbus_pkg::N_MASTERS],
	input conbus_pkg::gnt_idx_t gnt
);

	logic [conbus_pkg::N_MASTERS-1:0] acks;
	logic [conbus_pkg::N_MASTERS-1:0] cycs;
	// owner still holding its cycle
	logic owner_busy;

	always_comb begin
		for (int i = 0; i < conbus_pkg::N_MASTERS; i++) begin
			acks[i] = m_bus_o[i].ack;
			cycs[i] = m_bus_i[i].cyc;
		end
	end

	assign owner_busy = (gnt < 3'd6) && cycs[gnt];

	// one ack per request, never two cycles in a row
	ack_pulse: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
		(acks != '0) |=> (acks == '0)) else $error("ack held past one cycle");
	ack_needs_cyc: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
		(acks & ~cycs) == '0) else $error("ack to a master without cyc");
	gnt_held: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
		owner_busy |=> $stable(gnt)) else $error("grant moved under a busy owner");
	gnt_range: assert property (@(posedge sys_clk) disable iff (!rst_n_i) gnt <= 3'd5)
		else $error("grant out of range");

endmodule

bind conbus6x1 conbus_asserts u_asserts (
	.sys_clk (sys_clk),
	.rst_n_i (rst_n_i),
	.m_bus_i (m_bus_i),
	.m_bus_o (m_bus_o),
	.gnt     (gnt)
);

//--- bench/conbus_tb.sv
`timescale 1ns/1ps
// testbench for the six-master wishbone subsystem
// table-driven transfers checked against a byte-lane reference memory
module conbus_tb;

	localparam int TIMEOUT = 100;

	typedef struct packed {
		conbus_pkg::gnt_idx_t m;
		logic                 we;
		conbus_pkg::wb_adr_t  adr;
		conbus_pkg::wb_sel_t  sel;
		conbus_pkg::wb_dat_t  dat;
		logic                 all;
	} entry_t;

	logic sys_clk;
	logic rst_n_i;
	conbus_pkg::wb_m2s_t m_m2s [conbus_pkg::N_MASTERS];
	conbus_pkg::wb_s2m_t m_s2m [conbus_pkg::N_MASTERS];

	// expected memory contents
	conbus_pkg::wb_dat_t ref_mem [conbus_pkg::SRAM_WORDS];
	entry_t tab [$];
	logic [31:0] lfsr;

	conbus_top DUT (
		.sys_clk (sys_clk),
		.rst_n_i (rst_n_i),
		.m_bus_i (m_m2s),
		.m_bus_o (m_s2m)
	);

	always #50 sys_clk = ~sys_clk;

	task automatic report_fail(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	task automatic check_dat(input string name, input conbus_pkg::wb_dat_t exp,
			input conbus_pkg::wb_dat_t got);
		if (got !== exp) begin
			report_fail($sformatf("[ERROR] %s expected %h got %h", name, exp, got));
		end
	endtask

	task automatic check_ack(input logic [conbus_pkg::N_MASTERS-1:0] exp,
			input logic [conbus_pkg::N_MASTERS-1:0] got);
		if (got !== exp) begin
			report_fail($sformatf("[ERROR] ack expected %h got %h", exp, got));
		end
	endtask

	task automatic check_gnt(input conbus_pkg::gnt_idx_t exp, input conbus_pkg::gnt_idx_t got);
		if (got !== exp) begin
			report_fail($sformatf("[ERROR] gnt expected %h got %h", exp, got));
		end
	endtask

	// galois lfsr, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic logic [conbus_pkg::N_MASTERS-1:0] ack_vec();
		logic [conbus_pkg::N_MASTERS-1:0] v;
		for (int i = 0; i < conbus_pkg::N_MASTERS; i++) begin
			v[i] = m_s2m[i].ack;
		end
		return v;
	endfunction

	// caller owns the clock edge, this only schedules the values
	task automatic drive_req(input int m, input logic we, input conbus_pkg::wb_adr_t adr,
			input conbus_pkg::wb_sel_t sel, input conbus_pkg::wb_dat_t dat);
		conbus_pkg::wb_m2s_t b;
		b = '0;
		b.adr = adr;
		b.sel = sel;
		b.dat = dat;
		b.we = we;
		b.cyc = 1'b1;
		b.stb = 1'b1;
		m_m2s[m] <= b;
	endtask

	task automatic release_bus(input int m);
		@(posedge sys_clk);
		m_m2s[m].cyc <= 1'b0;
		m_m2s[m].stb <= 1'b0;
	endtask

	// sampled on the falling edge, ack only for m and only at the end
	task automatic wait_ack(input int m, output conbus_pkg::wb_dat_t data);
		logic [conbus_pkg::N_MASTERS-1:0] acks;
		logic [conbus_pkg::N_MASTERS-1:0] only_m;
		int cnt;
		logic got;
		only_m = '0;
		only_m[m] = 1'b1;
		cnt = 0;
		got = 1'b0;
		while (!got) begin
			@(negedge sys_clk);
			acks = ack_vec();
			if (acks[m]) begin
				check_ack(only_m, acks);
				check_gnt(conbus_pkg::gnt_idx_t'(m), DUT.u_conbus.gnt);
				data = m_s2m[m].dat;
				got = 1'b1;
			end else begin
				check_ack('0, acks);
				cnt++;
				if (cnt > TIMEOUT) begin
					report_fail($sformatf("timed out waiting for ack on master %0d", m));
				end
			end
		end
	endtask

	// reference update, or read compare, once the ack is seen
	task automatic settle(input entry_t e, input conbus_pkg::wb_dat_t rd);
		logic [7:0] i;
		i = e.adr[9:2];
		if (e.we) begin
			for (int b = 0; b < 4; b++) begin
				if (e.sel[b]) begin
					ref_mem[i][8*b +: 8] = e.dat[8*b +: 8];
				end
			end
		end else begin
			check_dat($sformatf("m_bus_o[%0d].dat", e.m), ref_mem[i], rd);
			// read data fans out, every master sees the same word
			for (int j = 0; j < conbus_pkg::N_MASTERS; j++) begin
				check_dat($sformatf("m_bus_o[%0d].dat", j), ref_mem[i], m_s2m[j].dat);
			end
		end
	endtask

	task automatic single(input entry_t e);
		conbus_pkg::wb_dat_t rd;
		@(posedge sys_clk);
		drive_req(e.m, e.we, e.adr, e.sel, e.dat);
		wait_ack(e.m, rd);
		settle(e, rd);
		release_bus(e.m);
	endtask

	function automatic entry_t mk(input int m, input logic we, input logic [31:0] adr,
			input logic [3:0] sel, input logic [31:0] dat, input logic all);
		entry_t e;
		e.m = conbus_pkg::gnt_idx_t'(m);
		e.we = we;
		e.adr = adr;
		e.sel = sel;
		e.dat = dat;
		e.all = all;
		return e;
	endfunction

	// owner a keeps cyc high over a run, b must stay unacked
	task automatic long_run(input int a, input int b);
		entry_t ea;
		entry_t eb;
		conbus_pkg::wb_dat_t rd;
		eb = mk(b, 1'b0, 32'h0000_0300, 4'hf, '0, 1'b0);
		for (int k = 0; k < 6; k++) begin
			ea = mk(a, 1'b1, 32'h0000_0300 + 4 * k, 4'hf, 32'hc0de_0000 + k, 1'b0);
			@(posedge sys_clk);
			drive_req(a, ea.we, ea.adr, ea.sel, ea.dat);
			if (k == 1) begin
				drive_req(b, eb.we, eb.adr, eb.sel, eb.dat);
			end
			wait_ack(a, rd);
			settle(ea, rd);
		end
		release_bus(a);
		wait_ack(b, rd);
		settle(eb, rd);
		release_bus(b);
	endtask

	initial begin
		entry_t grp [$];
		conbus_pkg::wb_dat_t rd;
		logic [31:0] r;
		int i;
		sys_clk = 1'b0;
		rst_n_i = 1'b0;
		lfsr = 32'd93;
		for (int k = 0; k < conbus_pkg::N_MASTERS; k++) begin
			m_m2s[k] = '0;
		end
		repeat (16) @(posedge sys_clk);
		rst_n_i <= 1'b1;
		// quiet bus after reset
		for (int k = 0; k < 10; k++) begin
			@(negedge sys_clk);
			check_ack('0, ack_vec());
			check_gnt('0, DUT.u_conbus.gnt);
		end
		// every word known before any partial write or read
		for (int k = 0; k < conbus_pkg::SRAM_WORDS; k++) begin
			single(mk(0, 1'b1, k * 4, 4'hf, (k * 32'h9e37_79b1) ^ {4{k[7:0]}}, 1'b0));
		end
		// full word write and read back
		tab.push_back(mk(0, 1'b1, 32'h10, 4'hf, 32'h1234_5678, 1'b0));
		tab.push_back(mk(0, 1'b0, 32'h10, 4'hf, '0, 1'b0));
		// byte lane merges from several masters
		tab.push_back(mk(1, 1'b1, 32'h20, 4'h1, 32'haaaa_aa11, 1'b0));
		tab.push_back(mk(2, 1'b1, 32'h20, 4'h6, 32'hbb22_33bb, 1'b0));
		tab.push_back(mk(3, 1'b1, 32'h20, 4'h8, 32'h44cc_cccc, 1'b0));
		tab.push_back(mk(4, 1'b0, 32'h20, 4'hf, '0, 1'b0));
		tab.push_back(mk(5, 1'b1, 32'h424, 4'h5, 32'h0055_0066, 1'b0));
		tab.push_back(mk(1, 1'b0, 32'h24, 4'hf, '0, 1'b0));
		// park grant on 0, then all six at once
		tab.push_back(mk(0, 1'b0, 32'h10, 4'hf, '0, 1'b0));
		for (int k = 0; k < conbus_pkg::N_MASTERS; k++) begin
			tab.push_back(mk(k, 1'b1, 32'h40 + 4 * k, 4'hf, 32'h600d_0000 + k, 1'b1));
		end
		for (int k = 0; k < 40; k++) begin
			entry_t e;
			r = rand_bits(3);
			e.m = conbus_pkg::gnt_idx_t'(r % conbus_pkg::N_MASTERS);
			r = rand_bits(1);
			e.we = r[0];
			r = rand_bits(10);
			e.adr = {20'h0, r[9:0], 2'b00};
			r = rand_bits(4);
			e.sel = r[3:0];
			r = rand_bits(32);
			e.dat = r;
			e.all = 1'b0;
			tab.push_back(e);
		end
		i = 0;
		while (i < tab.size()) begin
			if (!tab[i].all) begin
				single(tab[i]);
				i++;
			end else begin
				grp.delete();
				while (i < tab.size() && tab[i].all) begin
					grp.push_back(tab[i]);
					i++;
				end
				@(posedge sys_clk);
				foreach (grp[g]) begin
					drive_req(grp[g].m, grp[g].we, grp[g].adr, grp[g].sel, grp[g].dat);
				end
				// acks must come in table order, one master at a time
				foreach (grp[g]) begin
					wait_ack(grp[g].m, rd);
					settle(grp[g], rd);
					release_bus(grp[g].m);
				end
			end
			// long run sits between the directed and random parts
			if (i == 15) begin
				long_run(2, 4);
			end
		end
		repeat (4) @(posedge sys_clk);
		$display("=== PASS ===");
		$finish;
	end

endmodule

//--- vlog.f
verilog/conbus_pkg.sv
verilog/conbus_arb6.sv
verilog/conbus6x1.sv
verilog/wb_sram.sv
verilog/conbus_top.sv
bench/conbus_asserts.sv
bench/conbus_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing -j 0
TOP       := conbus_tb
FLIST     := vlog.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q "=== PASS ===" $(LOG) || { echo "no verdict in log"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
